// File: sources.f
src/vadd_pkg.sv
src/vadd_fifo.sv
src/vadd_read_master.sv
src/vadd_adder.sv
src/vadd_write_master.sv
src/vadd_top.sv
verification/tb_clock_gen.sv
verification/tb_axi_mem.sv
verification/vadd_tb.sv

// File: Makefile
# Verilator build and regression run for the vadd kernel

TOP     ?= vadd_tb
SIM_DIR ?= sim_build
LOG     ?= $(SIM_DIR)/sim.log
VFLAGS  ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run $(TOP) and check $(LOG)"
	@echo "  clean  remove $(SIM_DIR)"
	@echo "variables: TOP SIM_DIR LOG VFLAGS"

test:
	mkdir -p $(SIM_DIR)
	verilator $(VFLAGS) --top-module $(TOP) -Mdir $(SIM_DIR) -o $(TOP) -f sources.f
	$(SIM_DIR)/$(TOP) | tee $(LOG)
	grep -q "^Regression passed$$" $(LOG)

clean:
	rm -rf $(SIM_DIR)

// File: verification/vadd_tb.sv
// top testbench of the vadd kernel, runs the regression against the behavioral AXI memory
`timescale 1ns/1ps
`default_nettype none

module vadd_tb;
  import vadd_pkg::*;

  localparam int       burst_len   = 16;
  localparam int       limit       = 4000;  // cycles per wait
  localparam addr_t    base_a      = 32'h0000_1000;
  localparam addr_t    base_b      = 32'h0000_2000;
  localparam addr_t    base_c      = 32'h0000_3000;
  localparam addr_t    burst_bytes = addr_t'(burst_len * 4);
  localparam axi_len_t max_len     = axi_len_t'(burst_len - 1);

  logic        clk, rst_n, ap_start, ap_rd_done, ap_wr_done;
  addr_t       a, b, c, araddr, awaddr;
  len_t        length_r;
  axi_len_t    arlen, awlen, cur_awlen, w_beat;
  logic        arvalid, arready, rvalid, rready, rlast;
  logic        awvalid, awready, wvalid, wready, wlast, bvalid, bready;
  logic [31:0] rdata, wdata;
  logic [31:0] ref_a [64];
  logic [31:0] ref_b [64];
  int          err_count = 0;
  int          tests_run = 0;
  int          tests_failed = 0;
  int          seed = 49;
  int          ar_count = 0;
  int          aw_count = 0;
  int          b_count = 0;
  int          b_base = 0;
  int          rd_pulses = 0;
  int          wr_pulses = 0;
  int          exp_bursts = 0;
  addr_t       next_a, next_b, next_c;
  logic        busy = 1'b0;
  logic        aborted = 1'b0;

  tb_clock_gen clock_i (.clk(clk), .rst_n(rst_n));

  tb_axi_mem mem_i (
    .clk(clk), .rst_n(rst_n),
    .arvalid(arvalid), .arready(arready), .araddr(araddr), .arlen(arlen),
    .rvalid(rvalid), .rready(rready), .rdata(rdata), .rlast(rlast),
    .awvalid(awvalid), .awready(awready), .awaddr(awaddr),
    .wvalid(wvalid), .wready(wready), .wdata(wdata), .wlast(wlast),
    .bvalid(bvalid), .bready(bready)
  );

  vadd_top #(.data_w(32), .burst_len(burst_len)) vadd_top_i (
    .ap_clk(clk), .rst_n(rst_n), .ap_start(ap_start),
    .ap_rd_done(ap_rd_done), .ap_wr_done(ap_wr_done),
    .a(a), .b(b), .c(c), .length_r(length_r),
    .m_axi_gmem_arvalid(arvalid), .m_axi_gmem_arready(arready),
    .m_axi_gmem_araddr(araddr), .m_axi_gmem_arlen(arlen),
    .m_axi_gmem_rvalid(rvalid), .m_axi_gmem_rready(rready),
    .m_axi_gmem_rdata(rdata), .m_axi_gmem_rlast(rlast),
    .m_axi_gmem_awvalid(awvalid), .m_axi_gmem_awready(awready),
    .m_axi_gmem_awaddr(awaddr), .m_axi_gmem_awlen(awlen),
    .m_axi_gmem_wvalid(wvalid), .m_axi_gmem_wready(wready),
    .m_axi_gmem_wdata(wdata), .m_axi_gmem_wlast(wlast),
    .m_axi_gmem_bvalid(bvalid), .m_axi_gmem_bready(bready)
  );

  task automatic flag_error(input string msg);
    err_count++;
    $display("Error at %0t ns: %s", $time, msg);
  endtask

  //////////////////////////////////////////////////////////////////////
  // protocol and timing checks
  //////////////////////////////////////////////////////////////////////
  ar_len_max: assert property (@(posedge clk) disable iff (!rst_n) arvalid |-> arlen <= max_len)
    else flag_error("arlen longer than a burst");
  aw_len_max: assert property (@(posedge clk) disable iff (!rst_n) awvalid |-> awlen <= max_len)
    else flag_error("awlen longer than a burst");
  ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
    arvalid && !arready |=> arvalid && $stable(araddr) && $stable(arlen))
    else flag_error("AR dropped or changed before arready");
  aw_hold: assert property (@(posedge clk) disable iff (!rst_n)
    awvalid && !awready |=> awvalid && $stable(awaddr) && $stable(awlen))
    else flag_error("AW dropped or changed before awready");
  w_hold: assert property (@(posedge clk) disable iff (!rst_n)
    wvalid && !wready |=> wvalid && $stable(wdata) && $stable(wlast))
    else flag_error("W dropped or changed before wready");
  rd_done_pulse: assert property (@(posedge clk) disable iff (!rst_n) ap_rd_done |=> !ap_rd_done)
    else flag_error("ap_rd_done longer than one cycle");
  wr_done_pulse: assert property (@(posedge clk) disable iff (!rst_n) ap_wr_done |=> !ap_wr_done)
    else flag_error("ap_wr_done longer than one cycle");
  zero_len_done: assert property (@(posedge clk) disable iff (!rst_n)
    ap_start && !busy && length_r == '0 |=> ap_rd_done && ap_wr_done)
    else flag_error("zero length run did not finish in one cycle");

  // bookkeeping of handshakes, burst addresses and beats
  always @(posedge clk) begin
    if (rst_n) begin
      if (ap_start && !busy) begin
        next_a     = a;
        next_b     = b;
        next_c     = c;
        b_base     = b_count;
        exp_bursts = (int'(length_r) + burst_len - 1) / burst_len;
      end
      if (arvalid && arready) begin
        ar_count++;
        assert (araddr == next_a || araddr == next_b)
          else flag_error("AR address out of sequence");
        if (araddr == next_a) next_a = next_a + burst_bytes;
        else next_b = next_b + burst_bytes;
      end
      if (awvalid && awready) begin
        aw_count++;
        cur_awlen = awlen;
        w_beat    = '0;
        assert (awaddr == next_c) else flag_error("AW address out of sequence");
        next_c = next_c + burst_bytes;
      end
      if (wvalid && wready) begin
        assert (wlast == (w_beat == cur_awlen)) else flag_error("wlast not on the last beat");
        w_beat = w_beat + 1'b1;
      end
      if (bvalid && bready) b_count++;
      if (ap_rd_done) rd_pulses++;
      if (ap_wr_done) begin
        wr_pulses++;
        assert (b_count - b_base == exp_bursts)
          else flag_error("ap_wr_done before the final B");
      end
      if (ap_start && !busy && length_r != '0) busy = 1'b1;
      else if (ap_wr_done) busy = 1'b0;
    end
  end

  task automatic load_vectors(input int len);
    for (int i = 0; i < len; i++) begin
      ref_a[i] = $random(seed);
      ref_b[i] = $random(seed);
      mem_i.store(base_a + addr_t'(4 * i), ref_a[i]);
      mem_i.store(base_b + addr_t'(4 * i), ref_b[i]);
      mem_i.store(base_c + addr_t'(4 * i), ~(ref_a[i] + ref_b[i]));  // stale c never matches
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // one run of the kernel, optionally poked with a second start
  //////////////////////////////////////////////////////////////////////
  task automatic run_test(input string name, input int len, input logic poke);
    int          errs_before;
    int          bursts;
    int          ar_before;
    int          aw_before;
    int          rd_before;
    int          wr_before;
    int          waited;
    logic [31:0] exp_sum;
    errs_before = err_count;
    bursts      = (len + burst_len - 1) / burst_len;
    load_vectors(len);
    @(posedge clk);
    ar_before = ar_count;
    aw_before = aw_count;
    rd_before = rd_pulses;
    wr_before = wr_pulses;
    ap_start <= 1'b1;
    length_r <= len_t'(len);
    waited = 0;
    @(posedge clk);
    ap_start <= 1'b0;
    while (!ap_wr_done && waited < limit) begin
      @(posedge clk);
      waited++;
      ap_start <= poke && ap_rd_done;  // reads finished, writes still running
    end
    if (!ap_wr_done) begin
      $display("timeout waiting for ap_wr_done in test %s", name);
      aborted = 1'b1;
    end else begin
      repeat (4) @(posedge clk);
      assert (rd_pulses - rd_before == 1 && wr_pulses - wr_before == 1)
        else flag_error("done pulses are not one pair");
      assert (ar_count - ar_before == 2 * bursts && aw_count - aw_before == bursts)
        else flag_error("unexpected number of bursts");
      for (int i = 0; i < len; i++) begin
        exp_sum = ref_a[i] + ref_b[i];
        assert (mem_i.read_word(base_c + addr_t'(4 * i)) == exp_sum)
          else flag_error($sformatf("c[%0d] is not a[%0d] + b[%0d]", i, i, i));
      end
    end
    tests_run++;
    if (err_count != errs_before || aborted) tests_failed++;
    $display("test %s %s", name, (err_count == errs_before && !aborted) ? "ok" : "failed");
  endtask

  initial begin
    int waited;
    ap_start = 1'b0;
    length_r = '0;
    a        = base_a;
    b        = base_b;
    c        = base_c;
    waited   = 0;
    while (!rst_n && waited < 20) begin
      @(posedge clk);
      waited++;
    end
    if (!rst_n) begin
      $display("reset was never released");
      aborted = 1'b1;
    end
    if (!aborted) run_test("len37_stalls", 37, 1'b0);
    if (!aborted) run_test("len0", 0, 1'b0);
    if (!aborted) run_test("start_mid_run", 40, 1'b1);
    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, err_count);
    if (err_count == 0 && !aborted) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule : vadd_tb

`default_nettype wire

// File: verification/tb_axi_mem.sv
// behavioral AXI4 memory slave for the vadd testbench, INCR full-word bursts with random gaps
`timescale 1ns/1ps
`default_nettype none

module tb_axi_mem #(
  parameter int seed_init = 49
) (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               arvalid,
  output logic               arready,
  input  vadd_pkg::addr_t    araddr,
  input  vadd_pkg::axi_len_t arlen,
  output logic               rvalid,
  input  logic               rready,
  output logic [31:0]        rdata,
  output logic               rlast,
  input  logic               awvalid,
  output logic               awready,
  input  vadd_pkg::addr_t    awaddr,
  input  logic               wvalid,
  output logic               wready,
  input  logic [31:0]        wdata,
  input  logic               wlast,
  output logic               bvalid,
  input  logic               bready
);
  import vadd_pkg::*;

  logic [31:0] mem [addr_t];  // sparse word store, byte addressed
  int          seed = seed_init;
  logic        rd_busy;
  addr_t       rd_addr;
  axi_len_t    rd_left;
  logic [1:0]  wr_phase;  // 0 address, 1 data, 2 response
  addr_t       wr_addr;

  function automatic logic random_ready();
    return ($random(seed) & 3) != 0;  // about three cycles in four
  endfunction

  function automatic logic [31:0] read_word(input addr_t addr);
    return mem.exists(addr) ? mem[addr] : '0;
  endfunction

  task automatic store(input addr_t addr, input logic [31:0] data);
    mem[addr] = data;
  endtask

  //////////////////////////////////////////////////////////////////////
  // read and write channels, one burst at a time each
  //////////////////////////////////////////////////////////////////////
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      arready  <= 1'b0;
      rvalid   <= 1'b0;
      rlast    <= 1'b0;
      rdata    <= '0;
      rd_busy  <= 1'b0;
      rd_addr  <= '0;
      rd_left  <= '0;
      awready  <= 1'b0;
      wready   <= 1'b0;
      bvalid   <= 1'b0;
      wr_phase <= 2'd0;
      wr_addr  <= '0;
    end else begin
      if (!rd_busy) begin
        if (arvalid && arready) begin
          arready <= 1'b0;
          rd_busy <= 1'b1;
          rd_addr <= araddr;
          rd_left <= arlen;
        end else begin
          arready <= random_ready();
        end
      end else if (rvalid && rready) begin
        rvalid <= 1'b0;  // gap of at least one cycle per beat
        rlast  <= 1'b0;
        if (rlast) begin
          rd_busy <= 1'b0;
        end else begin
          rd_addr <= rd_addr + 32'd4;
          rd_left <= rd_left - 1'b1;
        end
      end else if (!rvalid && random_ready()) begin
        rvalid <= 1'b1;
        rdata  <= read_word(rd_addr);
        rlast  <= (rd_left == '0);
      end

      case (wr_phase)
        2'd0: begin
          if (awvalid && awready) begin
            awready  <= 1'b0;
            wr_addr  <= awaddr;
            wr_phase <= 2'd1;
          end else begin
            awready <= random_ready();
          end
        end
        2'd1: begin
          wready <= random_ready();
          if (wvalid && wready) begin
            mem[wr_addr] = wdata;
            wr_addr <= wr_addr + 32'd4;
            if (wlast) begin
              wready   <= 1'b0;
              wr_phase <= 2'd2;
            end
          end
        end
        default: begin
          if (bvalid && bready) begin
            bvalid   <= 1'b0;
            wr_phase <= 2'd0;
          end else if (!bvalid) begin
            bvalid <= random_ready();  // late B now and then
          end
        end
      endcase
    end
  end

endmodule : tb_axi_mem

`default_nettype wire

// File: verification/tb_clock_gen.sv
// clock and reset source of the vadd testbench, 40 ns period with reset held for 4 cycles
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
  parameter int half_ns      = 20,
  parameter int reset_cycles = 4
) (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #(half_ns) clk = ~clk;
  end

  initial begin
    rst_n = 1'b0;
    repeat (reset_cycles) @(posedge clk);
    rst_n <= 1'b1;  // released on a rising edge
  end

endmodule : tb_clock_gen

`default_nettype wire

// File: src/vadd_top.sv
// top level of the vadd kernel datapath, linking the AXI4 masters, the FIFOs and the adder
`timescale 1ns/1ps
`default_nettype none

module vadd_top #(
  parameter int data_w     = 32,
  parameter int burst_len  = 16,
  parameter int fifo_depth = 2 * burst_len
) (
  input  logic               ap_clk,
  input  logic               rst_n,
  input  logic               ap_start,
  output logic               ap_rd_done,
  output logic               ap_wr_done,
  input  vadd_pkg::addr_t    a,
  input  vadd_pkg::addr_t    b,
  input  vadd_pkg::addr_t    c,
  input  vadd_pkg::len_t     length_r,
  // AXI4 read channels
  output logic               m_axi_gmem_arvalid,
  input  logic               m_axi_gmem_arready,
  output vadd_pkg::addr_t    m_axi_gmem_araddr,
  output vadd_pkg::axi_len_t m_axi_gmem_arlen,
  input  logic               m_axi_gmem_rvalid,
  output logic               m_axi_gmem_rready,
  input  logic [data_w-1:0]  m_axi_gmem_rdata,
  input  logic               m_axi_gmem_rlast,
  // AXI4 write channels
  output logic               m_axi_gmem_awvalid,
  input  logic               m_axi_gmem_awready,
  output vadd_pkg::addr_t    m_axi_gmem_awaddr,
  output vadd_pkg::axi_len_t m_axi_gmem_awlen,
  output logic               m_axi_gmem_wvalid,
  input  logic               m_axi_gmem_wready,
  output logic [data_w-1:0]  m_axi_gmem_wdata,
  output logic               m_axi_gmem_wlast,
  input  logic               m_axi_gmem_bvalid,
  output logic               m_axi_gmem_bready
);
  import vadd_pkg::*;

  typedef logic [data_w-1:0] word_t;

  logic  start_go;
  logic  rd_idle;
  logic  wr_idle;
  logic  push_a;
  logic  push_b;
  word_t rd_data;
  logic  room_a;
  logic  room_b;
  logic  valid_a;
  logic  valid_b;
  word_t data_a;
  word_t data_b;
  logic  pair_pop;
  logic  sum_push;
  word_t sum_data;
  logic  room_c;
  logic  valid_c;
  word_t data_c;
  logic  pop_c;
  len_t  level_c;

  // a start while either master runs is dropped
  assign start_go = ap_start && rd_idle && wr_idle;

  //////////////////////////////////////////////////////////////////////
  // fetch, execute, store
  //////////////////////////////////////////////////////////////////////
  vadd_read_master #(.data_w(data_w), .burst_len(burst_len)) read_master_i (
    .ap_clk (ap_clk),             .rst_n    (rst_n),
    .start  (start_go),           .a        (a),
    .b      (b),                  .length_r (length_r),
    .arready(m_axi_gmem_arready), .rvalid   (m_axi_gmem_rvalid),
    .rdata  (m_axi_gmem_rdata),   .rlast    (m_axi_gmem_rlast),
    .room_a (room_a),             .room_b   (room_b),
    .arvalid(m_axi_gmem_arvalid), .araddr   (m_axi_gmem_araddr),
    .arlen  (m_axi_gmem_arlen),   .rready   (m_axi_gmem_rready),
    .push_a (push_a),             .push_b   (push_b),
    .push_data(rd_data),          .rd_done  (ap_rd_done),
    .idle   (rd_idle)
  );

  vadd_fifo #(.payload_t(word_t), .depth(fifo_depth), .burst_len(burst_len)) fifo_a_i (
    .ap_clk(ap_clk), .rst_n(rst_n), .push(push_a), .push_data(rd_data), .pop(pair_pop),
    .pop_data(data_a), .valid(valid_a), .has_room(room_a), .full(), .level()
  );

  vadd_fifo #(.payload_t(word_t), .depth(fifo_depth), .burst_len(burst_len)) fifo_b_i (
    .ap_clk(ap_clk), .rst_n(rst_n), .push(push_b), .push_data(rd_data), .pop(pair_pop),
    .pop_data(data_b), .valid(valid_b), .has_room(room_b), .full(), .level()
  );

  // has_room leaves space for the sum still in the adder register
  vadd_adder #(.data_w(data_w)) adder_i (
    .ap_clk(ap_clk), .rst_n(rst_n), .valid_a(valid_a), .valid_b(valid_b),
    .data_a(data_a), .data_b(data_b), .out_room(room_c),
    .pop(pair_pop), .push(sum_push), .push_data(sum_data)
  );

  vadd_fifo #(.payload_t(word_t), .depth(fifo_depth), .burst_len(burst_len)) fifo_c_i (
    .ap_clk(ap_clk), .rst_n(rst_n), .push(sum_push), .push_data(sum_data), .pop(pop_c),
    .pop_data(data_c), .valid(valid_c), .has_room(room_c), .full(), .level(level_c)
  );

  vadd_write_master #(.data_w(data_w), .burst_len(burst_len)) write_master_i (
    .ap_clk    (ap_clk),             .rst_n     (rst_n),
    .start     (start_go),           .c         (c),
    .length_r  (length_r),           .fifo_valid(valid_c),
    .fifo_data (data_c),             .fifo_level(level_c),
    .awready   (m_axi_gmem_awready), .wready    (m_axi_gmem_wready),
    .bvalid    (m_axi_gmem_bvalid),  .fifo_pop  (pop_c),
    .awvalid   (m_axi_gmem_awvalid), .awaddr    (m_axi_gmem_awaddr),
    .awlen     (m_axi_gmem_awlen),   .wvalid    (m_axi_gmem_wvalid),
    .wdata     (m_axi_gmem_wdata),   .wlast     (m_axi_gmem_wlast),
    .bready    (m_axi_gmem_bready),  .wr_done   (ap_wr_done),
    .idle      (wr_idle)
  );

endmodule : vadd_top

`default_nettype wire

// File: src/vadd_write_master.sv
// AXI4 write master of the vadd kernel, draining the result FIFO into vector c in bursts
`timescale 1ns/1ps
`default_nettype none

module vadd_write_master #(
  parameter int data_w    = 32,
  parameter int burst_len = 16
) (
  input  logic               ap_clk,
  input  logic               rst_n,
  input  logic               start,
  input  vadd_pkg::addr_t    c,
  input  vadd_pkg::len_t     length_r,
  input  logic               fifo_valid,
  input  logic [data_w-1:0]  fifo_data,
  input  vadd_pkg::len_t     fifo_level,
  input  logic               awready,
  input  logic               wready,
  input  logic               bvalid,
  output logic               fifo_pop,
  output logic               awvalid,
  output vadd_pkg::addr_t    awaddr,
  output vadd_pkg::axi_len_t awlen,
  output logic               wvalid,
  output logic [data_w-1:0]  wdata,
  output logic               wlast,
  output logic               bready,
  output logic               wr_done,
  output logic               idle
);
  import vadd_pkg::*;

  localparam addr_t burst_bytes = addr_t'(burst_len * (data_w / 8));
  localparam len_t  burst_words = len_t'(burst_len);

  typedef enum logic [2:0] {
    st_idle,
    st_wait,  // until the FIFO holds the whole next burst
    st_addr,
    st_data,
    st_resp
  } state_e;

  state_e   state;
  addr_t    addr_q;
  len_t     rem_q;
  len_t     beats;
  axi_len_t beat_cnt;
  logic     aw_open;
  logic     beat_ok;

  assign beats    = (rem_q > burst_words) ? burst_words : rem_q;
  assign wvalid   = (state == st_data) && fifo_valid;
  assign wdata    = fifo_data;
  assign wlast    = (state == st_data) && (beat_cnt == awlen);
  assign beat_ok  = wvalid && wready;
  assign fifo_pop = beat_ok;
  assign bready   = (state == st_resp);
  assign idle     = (state == st_idle);

  //////////////////////////////////////////////////////////////////////
  // per burst: address, data, response
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge ap_clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= st_idle;
      addr_q   <= '0;
      rem_q    <= '0;
      awvalid  <= 1'b0;
      awaddr   <= '0;
      awlen    <= '0;
      beat_cnt <= '0;
      wr_done  <= 1'b0;
    end else begin
      wr_done <= 1'b0;
      case (state)
        st_idle: begin
          if (start) begin
            addr_q <= c;
            rem_q  <= length_r;
            if (length_r == '0) wr_done <= 1'b1;
            else state <= st_wait;
          end
        end
        st_wait: begin
          if (fifo_level >= beats) begin
            awvalid <= 1'b1;
            awaddr  <= addr_q;
            awlen   <= axi_len_t'(beats - 1'b1);
            state   <= st_addr;
          end
        end
        st_addr: begin
          if (awready) begin
            awvalid  <= 1'b0;
            beat_cnt <= '0;
            addr_q   <= addr_q + burst_bytes;
            rem_q    <= rem_q - beats;
            state    <= st_data;
          end
        end
        st_data: begin
          if (beat_ok) begin
            beat_cnt <= beat_cnt + 1'b1;
            if (wlast) state <= st_resp;
          end
        end
        st_resp: begin
          if (bvalid) begin
            if (rem_q == '0) begin
              wr_done <= 1'b1;  // final B seen
              state   <= st_idle;
            end else begin
              state <= st_wait;
            end
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // tracks the window between an AW handshake and the last W beat
  always_ff @(posedge ap_clk or negedge rst_n) begin
    if (!rst_n) begin
      aw_open <= 1'b0;
    end else if (awvalid && awready) begin
      aw_open <= 1'b1;
    end else if (beat_ok && wlast) begin
      aw_open <= 1'b0;
    end
  end

  w_after_aw: assert property (@(posedge ap_clk) disable iff (!rst_n) wvalid |-> aw_open);

endmodule : vadd_write_master

`default_nettype wire

// File: src/vadd_adder.sv
// execute stage of the vadd kernel, pairing a and b words and registering their sum
`timescale 1ns/1ps
`default_nettype none

module vadd_adder #(
  parameter int data_w = 32
) (
  input  logic              ap_clk,
  input  logic              rst_n,
  input  logic              valid_a,
  input  logic              valid_b,
  input  logic [data_w-1:0] data_a,
  input  logic [data_w-1:0] data_b,
  input  logic              out_room,
  output logic              pop,
  output logic              push,
  output logic [data_w-1:0] push_data
);

  // one pair per cycle when both operands wait and the result side has space
  assign pop = valid_a && valid_b && out_room;

  always_ff @(posedge ap_clk or negedge rst_n) begin
    if (!rst_n) begin
      push <= 1'b0;
    end else begin
      push <= pop;  // one cycle behind the pop
    end
  end

  always_ff @(posedge ap_clk) begin
    if (pop) push_data <= data_a + data_b;  // wraps at data_w bits
  end

endmodule : vadd_adder

`default_nettype wire

// File: src/vadd_read_master.sv
// AXI4 read master of the vadd kernel, fetching a and b in alternating bursts into two FIFOs
`timescale 1ns/1ps
`default_nettype none

module vadd_read_master #(
  parameter int data_w    = 32,
  parameter int burst_len = 16
) (
  input  logic               ap_clk,
  input  logic               rst_n,
  input  logic               start,
  input  vadd_pkg::addr_t    a,
  input  vadd_pkg::addr_t    b,
  input  vadd_pkg::len_t     length_r,
  input  logic               arready,
  input  logic               rvalid,
  input  logic [data_w-1:0]  rdata,
  input  logic               rlast,
  input  logic               room_a,
  input  logic               room_b,
  output logic               arvalid,
  output vadd_pkg::addr_t    araddr,
  output vadd_pkg::axi_len_t arlen,
  output logic               rready,
  output logic               push_a,
  output logic               push_b,
  output logic [data_w-1:0]  push_data,
  output logic               rd_done,
  output logic               idle
);
  import vadd_pkg::*;

  localparam addr_t burst_bytes = addr_t'(burst_len * (data_w / 8));
  localparam len_t  burst_words = len_t'(burst_len);

  typedef enum logic [1:0] {
    st_idle,
    st_wait,  // waiting on FIFO room for the current vector
    st_addr,
    st_data
  } state_e;

  state_e   state;
  vec_e     cur;
  addr_t    addr_a;
  addr_t    addr_b;
  len_t     rem_a;
  len_t     rem_b;
  len_t     cur_rem;
  len_t     beats;
  logic     cur_room;
  logic     beat_ok;
  axi_len_t beat_cnt;

  assign cur_rem  = (cur == vec_a) ? rem_a : rem_b;
  assign cur_room = (cur == vec_a) ? room_a : room_b;
  assign beats    = (cur_rem > burst_words) ? burst_words : cur_rem;  // short final burst
  assign beat_ok  = rvalid && rready;

  assign rready    = (state == st_data);  // only while a burst is outstanding
  assign idle      = (state == st_idle);
  assign push_a    = beat_ok && (cur == vec_a);
  assign push_b    = beat_ok && (cur == vec_b);
  assign push_data = rdata;

  //////////////////////////////////////////////////////////////////////
  // burst sequencing, a then b then a again
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge ap_clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= st_idle;
      cur      <= vec_a;
      addr_a   <= '0;
      addr_b   <= '0;
      rem_a    <= '0;
      rem_b    <= '0;
      arvalid  <= 1'b0;
      araddr   <= '0;
      arlen    <= '0;
      beat_cnt <= '0;
      rd_done  <= 1'b0;
    end else begin
      rd_done <= 1'b0;
      case (state)
        st_idle: begin
          if (start) begin
            addr_a <= a;
            addr_b <= b;
            rem_a  <= length_r;
            rem_b  <= length_r;
            cur    <= vec_a;
            if (length_r == '0) rd_done <= 1'b1;  // nothing to fetch
            else state <= st_wait;
          end
        end
        st_wait: begin
          if (cur_room) begin
            arvalid <= 1'b1;
            araddr  <= (cur == vec_a) ? addr_a : addr_b;
            arlen   <= axi_len_t'(beats - 1'b1);
            state   <= st_addr;
          end
        end
        st_addr: begin
          if (arready) begin
            arvalid  <= 1'b0;
            beat_cnt <= '0;
            state    <= st_data;
            if (cur == vec_a) begin
              addr_a <= addr_a + burst_bytes;
              rem_a  <= rem_a - beats;
            end else begin
              addr_b <= addr_b + burst_bytes;
              rem_b  <= rem_b - beats;
            end
          end
        end
        st_data: begin
          if (beat_ok) begin
            beat_cnt <= beat_cnt + 1'b1;
            if (rlast) begin
              if ((cur == vec_b) && (rem_b == '0)) begin
                rd_done <= 1'b1;  // last beat of b
                state   <= st_idle;
              end else begin
                cur   <= (cur == vec_a) ? vec_b : vec_a;
                state <= st_wait;
              end
            end
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // memory must close each burst on the beat the AR asked for
  rlast_on_last_beat: assert property (@(posedge ap_clk) disable iff (!rst_n)
    beat_ok |-> (rlast == (beat_cnt == arlen)));

endmodule : vadd_read_master

`default_nettype wire

// File: src/vadd_fifo.sv
// synchronous first-word-fall-through FIFO, one per read vector and one for the write path
`timescale 1ns/1ps
`default_nettype none

module vadd_fifo #(
  parameter type payload_t = logic [31:0],
  parameter int  depth     = 32,
  parameter int  burst_len = 16
) (
  input  logic           ap_clk,
  input  logic           rst_n,
  input  logic           push,
  input  payload_t       push_data,
  input  logic           pop,
  output payload_t       pop_data,
  output logic           valid,
  output logic           has_room,
  output logic           full,
  output vadd_pkg::len_t level
);
  import vadd_pkg::*;

  localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
  localparam int cnt_w = $clog2(depth + 1);
  localparam logic [cnt_w-1:0] room_limit = cnt_w'(depth - burst_len);  // max count with a burst free

  payload_t         mem [depth];
  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  logic [cnt_w-1:0] count;

  function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
    return (ptr == ptr_w'(depth - 1)) ? '0 : ptr + 1'b1;  // wrap for any depth
  endfunction

  always_ff @(posedge ap_clk) begin
    if (push) mem[wr_ptr] <= push_data;
  end

  always_ff @(posedge ap_clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= next_ptr(wr_ptr);
      if (pop)  rd_ptr <= next_ptr(rd_ptr);
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // both or neither
      endcase
    end
  end

  assign pop_data = mem[rd_ptr];   // head word shows without a read strobe
  assign valid    = (count != '0);
  assign full     = (count == cnt_w'(depth));
  assign has_room = (count <= room_limit);
  assign level    = len_t'(count);

  no_push_when_full: assert property (@(posedge ap_clk) disable iff (!rst_n) push |-> !full);
  no_pop_when_empty: assert property (@(posedge ap_clk) disable iff (!rst_n) pop |-> valid);

endmodule : vadd_fifo

`default_nettype wire

// File: src/vadd_pkg.sv
// shared widths and types of the vadd datapath, imported by the RTL modules and the testbench
`default_nettype none

package vadd_pkg;

  //////////////////////////////////////////////////////////////////////
  // global memory and length widths
  //////////////////////////////////////////////////////////////////////
  localparam int addr_w    = 32;  // byte address into global memory
  localparam int len_w     = 32;  // vector length in words
  localparam int axi_len_w = 8;   // AXI4 AxLEN field

  typedef logic [addr_w-1:0]    addr_t;
  typedef logic [len_w-1:0]     len_t;
  typedef logic [axi_len_w-1:0] axi_len_t;  // beats minus one

  // which read FIFO the current R burst belongs to
  typedef enum logic {
    vec_a = 1'b0,
    vec_b = 1'b1
  } vec_e;

endpackage : vadd_pkg

`default_nettype wire
